//--- bench/pwm_spi_input.txt
# key a1 a2 data tag, hex: W addr data echo, R addr - value, N op addr -, A bytes - -
# P channel period highs, L addr - -, I - - - ; tag is the expected reply tag, 00 if unused
I 0 0 0 00
R 0 0 0 a5
W 0 10 10 a5
R 0 0 10 a5
W 1 10004 4 a5
R 1 0 4 a5
W 2 ffff ffff a5
W 5 ff f a5
R 5 0 f a5
P 0 10 8 00
P 1 10 20 00
P 2 10 0 00
W 5 e e a5
P 0 10 0 00
N 3 0 0 5a
N 1 7 0 5a
N 1 6 0 5a
N 2 9 0 5a
N ff 1 0 5a
R 0 0 10 a5
R 1 0 4 a5
A 3 0 0 a5
R 0 0 10 a5
R 6 0 24 a5
L 3 0 0 a5
W 0 0 0 a5
P 1 0 0 00
R 6 0 2c a5
W 0 8 8 a5
W 3 3 3 a5
P 2 8 6 00

//--- bench/pwm_spi_tb.sv
`timescale 1ns/1ps
`include "pwm_spi_settings.svh"

// Testbench for the SPI configured PWM, one test per line of the input file
module pwm_spi_tb;

  logic                     clk;
  logic                     resetn;
  logic                     sck;
  logic                     cs_n;
  logic                     copi;
  logic                     cipo;
  logic                     cipo_en;
  logic [`PWM_CHANNELS-1:0] pwm;

  // Random state, stepped once per bit taken
  logic [31:0] lfsr_state = 32'he433d004;
  int          check_errors = 0;
  int          pass_count = 0;
  int          fail_count = 0;
  longint      watchdog_ns = 0;
  string       lines[$];

  pwm_spi_top pwm_spi_top_inst (
    .clk     (clk),
    .resetn  (resetn),
    .sck     (sck),
    .cs_n    (cs_n),
    .copi    (copi),
    .cipo    (cipo),
    .cipo_en (cipo_en),
    .pwm     (pwm)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Inputs change 1 ns after the rising edge
  task automatic wait_clks(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic compare_values(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
    if (expected !== actual) begin
      $display("FAILED %s expected %0h actual %0h", name, expected, actual);
      check_errors++;
    end
  endtask

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[31]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  function automatic logic [63:0] make_cmd(input logic [7:0] op, input logic [7:0] addr,
                                           input logic [31:0] data);
    pwm_spi_pkg::spi_cmd_t c;
    c.reserved = '0;
    c.data     = data;
    c.addr     = addr;
    c.op       = pwm_spi_pkg::opcode_e'(op);
    return c;
  endfunction

  // Mode 0 host, LSB byte first, MSB bit first, half period of 4 clk
  task automatic spi_transfer(input logic [63:0] word, input int nbytes,
                              output logic [63:0] rx);
    logic en_low;
    rx     = '0;
    en_low = 1'b0;
    cs_n   = 1'b0;
    wait_clks(4);
    for (int b = 0; b < nbytes; b++) begin
      for (int i = 7; i >= 0; i--) begin
        copi = word[b*8+i];
        wait_clks(4);
        // Sample on our own rising edge
        if (!cipo_en) en_low = 1'b1;
        rx[b*8+i] = cipo;
        sck = 1'b1;
        wait_clks(4);
        sck = 1'b0;
      end
    end
    wait_clks(4);
    cs_n = 1'b1;
    copi = 1'b0;
    // Deselect gap of more than 8 clk
    wait_clks(10);
    if (en_low) begin
      $display("ERROR: cipo_en was low while cs_n was asserted");
      check_errors++;
    end
  endtask

  // Command word, then a NOP that brings back its reply
  task automatic run_command(input logic [7:0] op, input logic [7:0] addr,
                             input logic [31:0] data, output pwm_spi_pkg::spi_reply_t rep);
    logic [63:0] rx;
    spi_transfer(make_cmd(op, addr, data), 8, rx);
    spi_transfer(make_cmd(pwm_spi_pkg::OP_NOP, 8'h00, '0), 8, rx);
    rep = pwm_spi_pkg::spi_reply_t'(rx);
  endtask

  task automatic measure_pwm(input int ch, input int window, output int highs);
    highs = 0;
    for (int i = 0; i < window; i++) begin
      wait_clks(1);
      if (pwm[ch]) highs++;
    end
  endtask

  task automatic run_line(input string line);
    logic [7:0]              key;
    logic [31:0]             a1;
    logic [31:0]             a2;
    logic [31:0]             exp_data;
    logic [7:0]              exp_tag;
    logic [31:0]             rnd;
    logic [63:0]             rx;
    pwm_spi_pkg::spi_reply_t rep;
    int                      n;
    int                      highs;
    n = $sscanf(line, "%c %h %h %h %h", key, a1, a2, exp_data, exp_tag);
    if (n != 5) begin
      $display("ERROR: input line could not be parsed");
      check_errors++;
      return;
    end
    case (key)
      "I": begin
        // Idle outputs and reset reply before any command
        compare_values("pwm", '0, pwm);
        compare_values("cipo_en", '0, cipo_en);
        spi_transfer(make_cmd(pwm_spi_pkg::OP_NOP, 8'h00, '0), 8, rx);
        rep = pwm_spi_pkg::spi_reply_t'(rx);
        compare_values("reply.tag", exp_tag, rep.tag);
        compare_values("reply.data", exp_data, rep.data);
      end
      "W", "R", "N": begin
        if (key == "W") run_command(pwm_spi_pkg::OP_WRITE, a1[7:0], a2, rep);
        else if (key == "R") run_command(pwm_spi_pkg::OP_READ, a1[7:0], '0, rep);
        // Raw opcode and address, data set so a wrong write would show
        else run_command(a1[7:0], a2[7:0], 32'h0000ffff, rep);
        compare_values("reply.tag", exp_tag, rep.tag);
        compare_values("reply.addr", (key == "N") ? a2[7:0] : a1[7:0], rep.addr);
        compare_values("reply.data", exp_data, rep.data);
      end
      "A": begin
        // Partial period write, then a full NOP
        spi_transfer(make_cmd(pwm_spi_pkg::OP_WRITE, 8'h00, 32'h00000bad), a1, rx);
        spi_transfer(make_cmd(pwm_spi_pkg::OP_NOP, 8'h00, '0), 8, rx);
        rep = pwm_spi_pkg::spi_reply_t'(rx);
        compare_values("reply.tag", exp_tag, rep.tag);
        compare_values("reply.data", exp_data, rep.data);
      end
      "P": begin
        // Two periods, or a fixed window for a stopped counter
        measure_pwm(a1, (a2 == 0) ? 64 : 2 * a2, highs);
        compare_values("pwm high count", exp_data, highs);
      end
      "L": begin
        draw_bits(`PWM_CNT_W, rnd);
        run_command(pwm_spi_pkg::OP_WRITE, a1[7:0], rnd, rep);
        compare_values("reply.tag", exp_tag, rep.tag);
        compare_values("reply.data", rnd, rep.data);
        run_command(pwm_spi_pkg::OP_READ, a1[7:0], '0, rep);
        compare_values("reply.tag", exp_tag, rep.tag);
        compare_values("reply.data", rnd, rep.data);
      end
      default: begin
        $display("ERROR: unknown keyword in input line");
        check_errors++;
      end
    endcase
  endtask

  initial begin
    int    fd;
    int    rc;
    int    err_before;
    string line;
    resetn = 1'b1;
    sck    = 1'b0;
    cs_n   = 1'b1;
    copi   = 1'b0;
    fd = $fopen("bench/pwm_spi_input.txt", "r");
    if (fd == 0) begin
      $display("ERROR: input file could not be opened");
      $display("** FAIL **");
      $finish;
    end else begin
      // Keep test lines only, without the newline
      while (!$feof(fd)) begin
        line = "";
        rc = $fgets(line, fd);
        if (rc > 0 && line.len() > 1 && line.getc(0) != "#") begin
          if (line.getc(line.len() - 1) == "\n") line = line.substr(0, line.len() - 2);
          lines.push_back(line);
        end
      end
      $fclose(fd);
      // Two words of 64 bits at 8 clk each plus gap, per line
      watchdog_ns = longint'(lines.size()) * (64 * 8 + 64) * 10 * 2;
      wait_clks(4);
      resetn = 1'b0;
      wait_clks(4);
      foreach (lines[idx]) begin
        err_before = check_errors;
        run_line(lines[idx]);
        if (check_errors == err_before) begin
          pass_count++;
          $display("test %0d [%s] passed", idx + 1, lines[idx]);
        end else begin
          fail_count++;
          $display("test %0d [%s] failed", idx + 1, lines[idx]);
        end
      end
      $display("tests passed %0d failed %0d", pass_count, fail_count);
      if (fail_count == 0 && pass_count > 0) begin
        $display("** PASS **");
      end else begin
        $display("** FAIL **");
      end
      $finish;
    end
  end

  // Armed once the line count is known
  initial begin
    wait (watchdog_ns > 0);
    #(watchdog_ns);
    $display("ERROR: watchdog expired after %0d ns", watchdog_ns);
    $display("** FAIL **");
    $finish;
  end

endmodule

//--- hw/pwm_channel_bank.sv
`timescale 1ns/1ps
`include "pwm_spi_settings.svh"

// Shared period counter feeding one comparator per channel
module pwm_channel_bank (
  input  logic                     clk,
  input  logic                     resetn,
  input  pwm_spi_pkg::pwm_cfg_t    cfg,
  output logic [`PWM_CHANNELS-1:0] pwm
);

  // Runs 0 .. period-1, stuck at 0 when period is 0
  logic [`PWM_CNT_W-1:0] cnt;
  logic                  period_zero;
  logic                  period_end;

  assign period_zero = (cfg.period == '0);
  // Also catches a period lowered below the running count
  assign period_end  = (cnt >= cfg.period - 1'b1);

  always_ff @(posedge clk) begin
    if (resetn) begin
      cnt <= '0;
    end else if (period_zero || period_end) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // Registered compare, so a new config shows one cycle later
  always_ff @(posedge clk) begin
    if (resetn) begin
      pwm <= '0;
    end else begin
      for (int i = 0; i < `PWM_CHANNELS; i++) begin
        // High for min(duty, period) counts of each period
        pwm[i] <= cfg.enable[i] && !period_zero && (cnt < cfg.duty[i]);
      end
    end
  end

  // Zero period silences every channel on the next cycle
  a_zero_period_quiet: assert property (
    @(posedge clk) disable iff (resetn)
    period_zero |=> (pwm == '0)
  );

endmodule

//--- hw/pwm_reg_block.sv
`timescale 1ns/1ps
`include "pwm_spi_settings.svh"

// Command decode, configuration registers and reply builder
module pwm_reg_block (
  input  logic                    clk,
  input  logic                    resetn,
  input  pwm_spi_pkg::spi_cmd_t   cmd,
  input  logic                    cmd_strobe,
  output pwm_spi_pkg::spi_reply_t reply,
  output pwm_spi_pkg::pwm_cfg_t   cfg
);

  // Complete words seen, NAK ones included
  logic [`PWM_SPI_DATA_W-1:0] cmd_count;

  // Read value and echoed write value for the current address
  logic [`PWM_SPI_DATA_W-1:0] rd_data;
  logic [`PWM_SPI_DATA_W-1:0] wr_field;

  logic addr_rd_ok;
  logic addr_wr_ok;
  // Addresses 1..4 map to duty 0..3
  logic [1:0] duty_idx;

  // Top address is the read-only count
  assign addr_rd_ok = (cmd.addr < `PWM_REG_COUNT);
  assign addr_wr_ok = (cmd.addr < `PWM_REG_COUNT - 1);
  assign duty_idx   = cmd.addr[1:0] - 2'd1;

  // Register read mux, zero extended
  always_comb begin
    rd_data = '0;
    case (cmd.addr)
      8'd0: rd_data[`PWM_CNT_W-1:0] = cfg.period;
      8'd1, 8'd2, 8'd3, 8'd4: rd_data[`PWM_CNT_W-1:0] = cfg.duty[duty_idx];
      8'd5: rd_data[`PWM_CHANNELS-1:0] = cfg.enable;
      // Count before this command is applied
      8'd6: rd_data = cmd_count;
      default: rd_data = '0;
    endcase
  end

  // Field a write actually stores, echoed in the reply
  always_comb begin
    wr_field = '0;
    if (cmd.addr == 8'd5) begin
      wr_field[`PWM_CHANNELS-1:0] = cmd.data[`PWM_CHANNELS-1:0];
    end else begin
      wr_field[`PWM_CNT_W-1:0] = cmd.data[`PWM_CNT_W-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (resetn) begin
      cfg            <= '0;
      cmd_count      <= '0;
      reply.reserved <= '0;
      reply.data     <= '0;
      reply.addr     <= '0;
      reply.tag      <= pwm_spi_pkg::RC_IDLE;
    end else if (cmd_strobe) begin
      cmd_count      <= cmd_count + 1'b1;
      reply.reserved <= '0;
      reply.addr     <= cmd.addr;
      // Default is NAK with no data, valid cases override
      reply.tag      <= pwm_spi_pkg::RC_NAK;
      reply.data     <= '0;
      case (cmd.op)
        pwm_spi_pkg::OP_NOP: begin
          reply.tag <= pwm_spi_pkg::RC_ACK;
        end
        pwm_spi_pkg::OP_WRITE: begin
          if (addr_wr_ok) begin
            reply.tag  <= pwm_spi_pkg::RC_ACK;
            reply.data <= wr_field;
            if (cmd.addr == 8'd0) begin
              cfg.period <= cmd.data[`PWM_CNT_W-1:0];
            end else if (cmd.addr == 8'd5) begin
              cfg.enable <= cmd.data[`PWM_CHANNELS-1:0];
            end else begin
              cfg.duty[duty_idx] <= cmd.data[`PWM_CNT_W-1:0];
            end
          end
        end
        pwm_spi_pkg::OP_READ: begin
          if (addr_rd_ok) begin
            reply.tag  <= pwm_spi_pkg::RC_ACK;
            reply.data <= rd_data;
          end
        end
        default: begin
          // Unknown opcode, registers untouched
          reply.tag <= pwm_spi_pkg::RC_NAK;
        end
      endcase
    end
  end

  // Host only ever sees a defined reply tag
  a_tag_legal: assert property (
    @(posedge clk) disable iff (resetn)
    reply.tag inside {pwm_spi_pkg::RC_IDLE, pwm_spi_pkg::RC_ACK, pwm_spi_pkg::RC_NAK}
  );

endmodule

//--- hw/pwm_spi_pkg.sv
`include "pwm_spi_settings.svh"

package pwm_spi_pkg;

  // Command opcode, lowest byte of the word
  typedef enum logic [7:0] {
    OP_NOP   = 8'h00,
    OP_WRITE = 8'h01,
    OP_READ  = 8'h02
  } opcode_e;

  // Reply tag in the same position as the opcode
  typedef enum logic [7:0] {
    RC_IDLE = 8'h00,
    RC_ACK  = 8'hA5,
    RC_NAK  = 8'h5A
  } reply_code_e;

  // Host to device word, first byte on the wire is op
  typedef struct packed {
    logic [`PWM_SPI_RSVD_W-1:0] reserved;
    logic [`PWM_SPI_DATA_W-1:0] data;
    logic [`PWM_SPI_ADDR_W-1:0] addr;
    opcode_e                    op;
  } spi_cmd_t;

  // Device to host word, shifted out during the next transfer
  typedef struct packed {
    logic [`PWM_SPI_RSVD_W-1:0] reserved;
    logic [`PWM_SPI_DATA_W-1:0] data;
    logic [`PWM_SPI_ADDR_W-1:0] addr;
    reply_code_e                tag;
  } spi_reply_t;

  // Live PWM configuration from the register block
  typedef struct packed {
    logic [`PWM_CNT_W-1:0]                        period;
    // Duty per channel, entry 0 is channel 0
    logic [`PWM_CHANNELS-1:0][`PWM_CNT_W-1:0]     duty;
    logic [`PWM_CHANNELS-1:0]                     enable;
  } pwm_cfg_t;

endpackage

//--- hw/pwm_spi_settings.svh
`ifndef PWM_SPI_SETTINGS_SVH
`define PWM_SPI_SETTINGS_SVH

// One SPI command word and its byte split
`define PWM_SPI_WORD_W 64
`define PWM_SPI_WORD_BYTES 8
`define PWM_SPI_BYTE_W 8
// Index widths for bytes in a word and bits in a byte
`define PWM_SPI_BYTE_IDX_W 3
`define PWM_SPI_BIT_IDX_W 3

// Command word fields above the opcode
`define PWM_SPI_ADDR_W 8
`define PWM_SPI_DATA_W 32
`define PWM_SPI_RSVD_W 16

// PWM counter width, channel count and register map size
`define PWM_CNT_W 16
`define PWM_CHANNELS 4
`define PWM_REG_COUNT 7

`endif

//--- hw/pwm_spi_top.sv
`timescale 1ns/1ps
`include "pwm_spi_settings.svh"

// SPI configured four channel PWM
module pwm_spi_top (
  input  logic                     clk,
  input  logic                     resetn,
  input  logic                     sck,
  input  logic                     cs_n,
  input  logic                     copi,
  output logic                     cipo,
  output logic                     cipo_en,
  output logic [`PWM_CHANNELS-1:0] pwm
);

  // Byte level between link and framer
  logic [`PWM_SPI_BYTE_W-1:0] rx_byte;
  logic [`PWM_SPI_BYTE_W-1:0] tx_byte;
  logic                       rx_byte_ready;
  logic                       selected;

  // Word level between framer and registers
  pwm_spi_pkg::spi_cmd_t      cmd;
  pwm_spi_pkg::spi_reply_t    reply;
  logic                       cmd_strobe;

  // Live configuration into the channels
  pwm_spi_pkg::pwm_cfg_t      cfg;

  spi_byte_link spi_byte_link_inst (
    .clk           (clk),
    .resetn        (resetn),
    .sck           (sck),
    .cs_n          (cs_n),
    .copi          (copi),
    .tx_byte       (tx_byte),
    .cipo          (cipo),
    .cipo_en       (cipo_en),
    .rx_byte       (rx_byte),
    .rx_byte_ready (rx_byte_ready),
    .selected      (selected)
  );

  spi_word_framer spi_word_framer_inst (
    .clk           (clk),
    .resetn        (resetn),
    .rx_byte       (rx_byte),
    .rx_byte_ready (rx_byte_ready),
    .selected      (selected),
    .reply         (reply),
    .tx_byte       (tx_byte),
    .cmd           (cmd),
    .cmd_strobe    (cmd_strobe)
  );

  pwm_reg_block pwm_reg_block_inst (
    .clk        (clk),
    .resetn     (resetn),
    .cmd        (cmd),
    .cmd_strobe (cmd_strobe),
    .reply      (reply),
    .cfg        (cfg)
  );

  pwm_channel_bank pwm_channel_bank_inst (
    .clk    (clk),
    .resetn (resetn),
    .cfg    (cfg),
    .pwm    (pwm)
  );

endmodule

//--- hw/spi_byte_link.sv
`timescale 1ns/1ps
`include "pwm_spi_settings.svh"

// SPI mode 0 peripheral that moves one byte at a time MSB first
module spi_byte_link (
  input  logic                       clk,
  input  logic                       resetn,
  input  logic                       sck,
  input  logic                       cs_n,
  input  logic                       copi,
  input  logic [`PWM_SPI_BYTE_W-1:0] tx_byte,
  output logic                       cipo,
  output logic                       cipo_en,
  output logic [`PWM_SPI_BYTE_W-1:0] rx_byte,
  output logic                       rx_byte_ready,
  output logic                       selected
);

  // Two sync stages per input plus a third sck stage for edge detect
  logic [2:0] sck_q;
  logic [1:0] copi_q;
  logic [1:0] cs_n_q;

  // Receive count goes up and transmit count goes down
  logic [`PWM_SPI_BIT_IDX_W-1:0] rx_cnt;
  logic [`PWM_SPI_BIT_IDX_W-1:0] tx_cnt;

  logic sck_rise;
  logic sck_fall;

  // Edges seen on the synchronized sck
  assign sck_rise = (sck_q[2:1] == 2'b01);
  assign sck_fall = (sck_q[2:1] == 2'b10);

  // selected is the synced inverse of the active low cs_n
  assign selected = ~cs_n_q[1];
  assign cipo_en  = selected;

  // Line held low while deselected
  assign cipo = selected & tx_byte[tx_cnt];

  always_ff @(posedge clk) begin
    if (resetn) begin
      sck_q         <= '0;
      copi_q        <= '0;
      // Start deselected
      cs_n_q        <= '1;
      rx_cnt        <= '0;
      tx_cnt        <= '1;
      rx_byte_ready <= 1'b0;
    end else begin
      sck_q  <= {sck_q[1:0], sck};
      copi_q <= {copi_q[0], copi};
      cs_n_q <= {cs_n_q[0], cs_n};

      if (selected) begin
        if (sck_rise) begin
          rx_cnt <= rx_cnt + 1'b1;
          // High after the eighth bit and low again on the next rising edge
          rx_byte_ready <= &rx_cnt;
        end
        // Step to the next transmit bit and wrap to 7 at a byte boundary
        if (sck_fall) begin
          tx_cnt <= tx_cnt - 1'b1;
        end
      end else begin
        // Interrupted transfer restarts at bit 0
        rx_cnt <= '0;
        tx_cnt <= '1;
      end
    end
  end

  // Receive shifter where the MSB arrives first
  always_ff @(posedge clk) begin
    if (selected && sck_rise) begin
      rx_byte <= {rx_byte[`PWM_SPI_BYTE_W-2:0], copi_q[1]};
    end
  end

  // A byte only completes inside a selected transfer
  a_ready_needs_select: assert property (
    @(posedge clk) disable iff (resetn)
    $rose(rx_byte_ready) |-> selected
  );

endmodule

//--- hw/spi_word_framer.sv
`timescale 1ns/1ps
`include "pwm_spi_settings.svh"

// Eight bytes to one command word, little endian on the wire
module spi_word_framer (
  input  logic                       clk,
  input  logic                       resetn,
  input  logic [`PWM_SPI_BYTE_W-1:0] rx_byte,
  input  logic                       rx_byte_ready,
  input  logic                       selected,
  input  pwm_spi_pkg::spi_reply_t    reply,
  output logic [`PWM_SPI_BYTE_W-1:0] tx_byte,
  output pwm_spi_pkg::spi_cmd_t      cmd,
  output logic                       cmd_strobe
);

  // Ready level history for rising edge detect
  logic [1:0] ready_q;
  logic       ready_rise;

  // Bytes taken so far in this transfer
  logic [`PWM_SPI_BYTE_IDX_W-1:0] byte_cnt;

  logic [`PWM_SPI_WORD_W-1:0] word_q;
  logic [`PWM_SPI_WORD_W-1:0] reply_bits;

  assign ready_rise = (ready_q == 2'b01);

  assign cmd        = word_q;
  assign reply_bits = reply;

  // Reply byte for the slot being shifted, byte 0 while idle
  assign tx_byte = reply_bits[{byte_cnt, 3'b000} +: `PWM_SPI_BYTE_W];

  always_ff @(posedge clk) begin
    if (resetn) begin
      ready_q    <= '0;
      byte_cnt   <= '0;
      cmd_strobe <= 1'b0;
    end else begin
      ready_q <= {ready_q[0], rx_byte_ready};
      // Strobe is one cycle, raised only by the last byte
      cmd_strobe <= 1'b0;
      if (ready_rise) begin
        byte_cnt <= byte_cnt + 1'b1;
        if (byte_cnt == `PWM_SPI_WORD_BYTES - 1) begin
          cmd_strobe <= 1'b1;
        end
      end else if (!selected) begin
        // cs_n high drops a partial word
        byte_cnt <= '0;
      end
    end
  end

  // New byte enters at the top, so the first one ends up in bits 7:0
  always_ff @(posedge clk) begin
    if (ready_rise) begin
      word_q <= {rx_byte, word_q[`PWM_SPI_WORD_W-1:`PWM_SPI_BYTE_W]};
    end
  end

  // Eight bytes at least separate two words
  a_strobe_single: assert property (
    @(posedge clk) disable iff (resetn)
    cmd_strobe |=> !cmd_strobe
  );

endmodule

//--- pwm_spi_top.f
+incdir+hw
hw/pwm_spi_pkg.sv
hw/spi_byte_link.sv
hw/spi_word_framer.sv
hw/pwm_reg_block.sv
hw/pwm_channel_bank.sv
hw/pwm_spi_top.sv
bench/pwm_spi_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the PWM SPI testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module pwm_spi_tb -f pwm_spi_top.f \
  && ./obj_dir/Vpwm_spi_tb | tee sim.log \
  || { echo "build or simulation did not complete"; exit 1; }
grep -qF "** PASS **" sim.log \
  && echo "simulation result: passed" \
  || { echo "simulation result: failed"; exit 1; }
